//--- Bender.yml
package:
  name: pvr_top

sources:
  - rtl/pvr_pkg.sv
  - rtl/pvr_bus_if.sv
  - rtl/vram_client_if.sv
  - rtl/pvr_ctrl.sv
  - rtl/pvr_reg_file.sv
  - rtl/pvr_palette_ram.sv
  - rtl/vram_port_mux.sv
  - rtl/pvr_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_pvr_top.sv

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS = 100.0   // full clock period
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2.0) clock = ~clock;   // free running, 50% duty
	end

endmodule

`default_nettype wire

//--- dv/tb_pvr_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pvr_top;

	localparam int VRAM_AW = 22;         // vram width under test
	localparam int DRIVE_DLY = 5;        // ns after the rising edge
	localparam int OWNER_TIMEOUT = 8;    // cycles allowed for a handover
	localparam int OP_RD = 0;
	localparam int OP_WR = 1;
	localparam int OP_WR_NOCS = 2;       // write level without cs
	localparam logic [15:0] RW_ADDRS [8] = '{pvr_pkg::SOFTRESET_ADDR,
		pvr_pkg::STARTRENDER_ADDR, pvr_pkg::FB_W_CTRL_ADDR, pvr_pkg::FB_X_CLIP_ADDR,
		pvr_pkg::FB_Y_CLIP_ADDR, pvr_pkg::ISP_BACKGND_D_ADDR, pvr_pkg::ISP_BACKGND_T_ADDR,
		pvr_pkg::TEXT_CONTROL_ADDR};

	logic clock, reset_n, pvr_reg_cs, pvr_wr, param_word_swap, tex_word_swap;
	logic [15:0] pvr_addr;
	logic [31:0] pvr_din, pvr_dout;
	logic [31:0] ra_vram_wdata, ra_vram_rdata, isp_vram_wdata, isp_vram_rdata;
	logic ra_vram_rd, ra_vram_wr, isp_vram_rd, isp_vram_wr, vram_rd, vram_wr;
	logic [23:0] ra_vram_addr, isp_vram_addr;
	logic [7:0] isp_vram_burst_cnt, vram_burst_cnt;
	logic render_poly, render_to_tile, poly_drawn, tile_accum_done;
	logic [VRAM_AW-1:0] vram_addr;
	logic [31:0] vram_dout;
	logic [63:0] vram_din, tex_rdata;

	int checks = 0;
	int errors = 0;
	int op_q[$];                  // stimulus table with one entry per cycle
	logic [15:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [31:0] exp_q[$];        // expected pvr_dout for reads

	tb_clock_gen #(.PERIOD_NS(100.0)) u_clock_gen (.clock(clock));

	pvr_top #(.VRAM_ADDR_W(VRAM_AW)) u_pvr_top (
		.clock(clock), .reset_n(reset_n), .pvr_reg_cs(pvr_reg_cs), .pvr_addr(pvr_addr),
		.pvr_din(pvr_din), .pvr_wr(pvr_wr), .pvr_dout(pvr_dout),
		.param_word_swap(param_word_swap), .tex_word_swap(tex_word_swap),
		.ra_vram_rd(ra_vram_rd), .ra_vram_wr(ra_vram_wr), .ra_vram_addr(ra_vram_addr),
		.ra_vram_wdata(ra_vram_wdata), .ra_vram_rdata(ra_vram_rdata),
		.isp_vram_rd(isp_vram_rd), .isp_vram_wr(isp_vram_wr), .isp_vram_addr(isp_vram_addr),
		.isp_vram_wdata(isp_vram_wdata), .isp_vram_burst_cnt(isp_vram_burst_cnt),
		.isp_vram_rdata(isp_vram_rdata), .render_poly(render_poly),
		.render_to_tile(render_to_tile), .poly_drawn(poly_drawn),
		.tile_accum_done(tile_accum_done), .vram_rd(vram_rd), .vram_wr(vram_wr),
		.vram_addr(vram_addr), .vram_burst_cnt(vram_burst_cnt), .vram_dout(vram_dout),
		.vram_din(vram_din), .tex_rdata(tex_rdata)
	);

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic add_entry(input int op, input logic [15:0] addr, input logic [31:0] data,
			input logic [31:0] exp);
		op_q.push_back(op);
		addr_q.push_back(addr);
		data_q.push_back(data);
		exp_q.push_back(exp);
	endtask

	// a read is checked one edge after its address goes out
	task automatic run_table();
		int i;
		int prev_op;
		logic [31:0] prev_exp;
		prev_op = OP_WR;
		prev_exp = '0;
		for (i = 0; i <= op_q.size(); i++) begin
			@(posedge clock);
			#DRIVE_DLY;
			if (prev_op == OP_RD)
				check("pvr_dout", pvr_dout, prev_exp);
			if (i < op_q.size()) begin
				pvr_reg_cs = (op_q[i] != OP_WR_NOCS);   // a no-cs write must not land
				pvr_wr     = (op_q[i] != OP_RD);
				pvr_addr   = addr_q[i];
				pvr_din    = data_q[i];
				prev_op    = op_q[i];
				prev_exp   = exp_q[i];
			end else begin
				pvr_reg_cs = 1'b0;
				pvr_wr     = 1'b0;
			end
		end
		op_q.delete();
		addr_q.delete();
		data_q.delete();
		exp_q.delete();
	endtask

	task automatic drive_clients();
		ra_vram_addr       = $urandom;
		isp_vram_addr      = ~ra_vram_addr;          // every address bit differs between clients
		ra_vram_wdata      = $urandom;
		isp_vram_wdata     = $urandom;
		ra_vram_rd         = 1'b1;
		ra_vram_wr         = 1'b0;
		isp_vram_rd        = 1'b0;
		isp_vram_wr        = 1'b1;
		isp_vram_burst_cnt = 8'd2 + 8'($urandom % 250);   // never equal to one
	endtask

	// owner's request appears with its address cut to the vram width
	task automatic check_vram(input logic isp_side);
		check("vram_rd", vram_rd, isp_side ? isp_vram_rd : ra_vram_rd);
		check("vram_wr", vram_wr, isp_side ? isp_vram_wr : ra_vram_wr);
		check("vram_addr", vram_addr,
			isp_side ? isp_vram_addr[VRAM_AW-1:0] : ra_vram_addr[VRAM_AW-1:0]);
		check("vram_burst_cnt", vram_burst_cnt, isp_side ? isp_vram_burst_cnt : 8'd1);
		check("vram_dout", vram_dout, isp_side ? isp_vram_wdata : ra_vram_wdata);
	endtask

	task automatic wait_owner(input logic isp_side, output int cycles);
		logic [VRAM_AW-1:0] target;
		target = isp_side ? isp_vram_addr[VRAM_AW-1:0] : ra_vram_addr[VRAM_AW-1:0];
		cycles = 0;
		do begin
			@(posedge clock);
			#DRIVE_DLY;
			cycles++;
			render_poly     = 1'b0;   // strobes last a single cycle
			render_to_tile  = 1'b0;
			poly_drawn      = 1'b0;
			tile_accum_done = 1'b0;
		end while (vram_addr !== target && cycles < OWNER_TIMEOUT);
		if (vram_addr !== target) begin
			$display("timeout: vram port did not go to the %s within %0d cycles",
				isp_side ? "isp" : "region reader", OWNER_TIMEOUT);
			$display("TB FAILED");
			$finish;
		end
	endtask

	task automatic handover(input logic rp, input logic rt, input logic pd, input logic ta,
			input logic prev_isp, input logic isp_side);
		int cycles;
		@(posedge clock);
		#DRIVE_DLY;
		drive_clients();
		render_poly     = rp;
		render_to_tile  = rt;
		poly_drawn      = pd;
		tile_accum_done = ta;
		#1;
		check_vram(prev_isp);   // strobes act only at the next edge
		wait_owner(isp_side, cycles);
		check("owner_latency", cycles, 1);
		check_vram(isp_side);
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("test %s done, %0d errors", name, errors - errs_before);
	endtask

	initial begin
		int errs_at_start;
		logic [31:0] word;
		logic [9:0] pal_idx;
		void'($urandom(36));
		reset_n = 1'b0;
		{pvr_reg_cs, pvr_wr, param_word_swap, tex_word_swap} = '0;
		{pvr_addr, pvr_din, vram_din} = '0;
		{ra_vram_rd, ra_vram_wr, ra_vram_addr, ra_vram_wdata} = '0;
		{isp_vram_rd, isp_vram_wr, isp_vram_addr, isp_vram_wdata, isp_vram_burst_cnt} = '0;
		{render_poly, render_to_tile, poly_drawn, tile_accum_done} = '0;
		repeat (16) @(posedge clock);
		#DRIVE_DLY;
		reset_n = 1'b1;

		errs_at_start = errors;   // identity constants and cleared control regs
		add_entry(OP_RD, pvr_pkg::ID_ADDR, '0, pvr_pkg::PVR_ID_VALUE);
		add_entry(OP_RD, pvr_pkg::REVISION_ADDR, '0, pvr_pkg::PVR_REVISION_VALUE);
		for (int k = 0; k < 8; k++)
			add_entry(OP_RD, RW_ADDRS[k], '0, '0);
		run_table();
		@(posedge clock);
		#DRIVE_DLY;
		drive_clients();
		#DRIVE_DLY;
		check_vram(1'b0);   // region reader owns the port out of reset
		report_test("reset_values", errs_at_start);

		errs_at_start = errors;
		for (int k = 0; k < 8; k++) begin
			word = 32'hC0DE_0000 ^ {RW_ADDRS[k], ~RW_ADDRS[k]};
			add_entry(OP_WR, RW_ADDRS[k], word, '0);
			add_entry(OP_RD, RW_ADDRS[k], '0, word);
		end
		add_entry(OP_WR, pvr_pkg::ID_ADDR, 32'hFFFF_FFFF, '0);
		add_entry(OP_RD, pvr_pkg::ID_ADDR, '0, pvr_pkg::PVR_ID_VALUE);
		add_entry(OP_WR, pvr_pkg::REVISION_ADDR, 32'h0, '0);
		add_entry(OP_RD, pvr_pkg::REVISION_ADDR, '0, pvr_pkg::PVR_REVISION_VALUE);
		add_entry(OP_RD, 16'h0100, '0, pvr_pkg::PVR_REVISION_VALUE);   // hole holds dout
		add_entry(OP_RD, 16'h0FFC, '0, pvr_pkg::PVR_REVISION_VALUE);   // just under the window
		run_table();
		report_test("registers", errs_at_start);

		errs_at_start = errors;
		for (int k = 0; k < 6; k++) begin
			pal_idx = $urandom;
			word = $urandom;
			add_entry(OP_WR, 16'h1000 | {pal_idx, 2'b00}, word, '0);
			add_entry(OP_RD, 16'h1000 | {pal_idx, 2'b00}, '0, word);
			add_entry(OP_WR_NOCS, 16'h1000 | {pal_idx, 2'b00}, ~word, '0);
			add_entry(OP_RD, 16'h1000 | {pal_idx, 2'b00}, '0, word);
		end
		run_table();
		report_test("palette", errs_at_start);

		errs_at_start = errors;
		handover(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);   // render_poly
		handover(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);   // poly_drawn
		handover(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);   // render_to_tile
		handover(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);   // tile_accum_done
		handover(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);   // clear wins over a same-cycle set
		report_test("ownership", errs_at_start);

		errs_at_start = errors;
		for (int v = 0; v < 4; v++) begin
			for (int k = 0; k < 16; k++) begin
				@(posedge clock);
				#DRIVE_DLY;
				vram_din = {$urandom, $urandom};
				param_word_swap = k[0];
				ra_vram_addr[pvr_pkg::LANE_SEL_BIT]  = k[1];
				isp_vram_addr[pvr_pkg::LANE_SEL_BIT] = k[2];
				tex_word_swap = k[3];
				#DRIVE_DLY;
				check("ra_vram_rdata", ra_vram_rdata,
					(k[1] != k[0]) ? vram_din[63:32] : vram_din[31:0]);
				check("isp_vram_rdata", isp_vram_rdata,
					(k[2] != k[0]) ? vram_din[63:32] : vram_din[31:0]);
				check("tex_rdata", tex_rdata,
					k[3] ? {vram_din[31:0], vram_din[63:32]} : vram_din);
			end
		end
		report_test("lanes_swap", errs_at_start);

		$display("checks=%0d errors=%0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
rtl/pvr_pkg.sv
rtl/pvr_bus_if.sv
rtl/vram_client_if.sv
rtl/pvr_ctrl.sv
rtl/pvr_reg_file.sv
rtl/pvr_palette_ram.sv
rtl/vram_port_mux.sv
rtl/pvr_top.sv
dv/tb_clock_gen.sv
dv/tb_pvr_top.sv

//--- rtl/pvr_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pvr_bus_if;

	logic                           cs;      // register block select
	logic [pvr_pkg::REG_ADDR_W-1:0] addr;    // byte address, also drives the read mux
	logic [pvr_pkg::REG_DATA_W-1:0] wdata;
	logic                           wr;      // write level, qualified by cs

	modport host (
		output cs, addr, wdata, wr
	);

	modport sink (
		input cs, addr, wdata, wr
	);

endinterface

`default_nettype wire

//--- rtl/pvr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_ctrl (
	input  wire     clock,
	input  wire     reset_n,
	pvr_bus_if.sink bus,
	input  wire     render_poly,       // isp takes the port
	input  wire     render_to_tile,
	input  wire     poly_drawn,        // isp hands the port back
	input  wire     tile_accum_done,
	output logic    reg_we,
	output logic    pal_we,
	output logic    pal_sel,
	output logic    isp_owns
);

	logic host_write;   // qualified write cycle from the host

	assign host_write = bus.cs && bus.wr;

	// palette window is a 4KB block, tag sits in the top nibble
	assign pal_sel = (bus.addr[pvr_pkg::REG_ADDR_W-1 -: 4] == pvr_pkg::PAL_WINDOW_TAG);

	assign reg_we = host_write && !pal_sel;   // control regs
	assign pal_we = host_write && pal_sel;    // palette words

	// vram ownership, region reader holds the port unless the isp is drawing
	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			isp_owns <= 1'b0;
		end else if (poly_drawn || tile_accum_done) begin
			isp_owns <= 1'b0;   // done beats a same-cycle render strobe
		end else if (render_poly || render_to_tile) begin
			isp_owns <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/pvr_palette_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_palette_ram (
	input  wire                            clock,
	pvr_bus_if.sink                        bus,
	input  wire                            pal_we,      // host write inside the window
	output logic [pvr_pkg::REG_DATA_W-1:0] pal_rdata
);

	localparam int PAL_DEPTH = 1 << pvr_pkg::PAL_INDEX_W;

	logic [pvr_pkg::REG_DATA_W-1:0]  pal_mem [PAL_DEPTH];
	logic [pvr_pkg::PAL_INDEX_W-1:0] pal_index;   // word index, byte bits dropped

	assign pal_index = bus.addr[pvr_pkg::PAL_INDEX_W+1:2];

	always_ff @(posedge clock) begin
		if (pal_we) begin
			pal_mem[pal_index] <= bus.wdata;
		end
	end

	// async read, the reg file output flop gives the one cycle latency
	assign pal_rdata = pal_mem[pal_index];

endmodule

`default_nettype wire

//--- rtl/pvr_pkg.sv
`default_nettype none

package pvr_pkg;

	parameter int REG_ADDR_W      = 16;   // host byte address
	parameter int REG_DATA_W      = 32;
	parameter int PAL_INDEX_W     = 10;   // 1024 palette words
	parameter int VRAM_REQ_ADDR_W = 24;   // client side, before truncation to the vram range
	parameter int LANE_SEL_BIT    = 22;   // upper 4MB half lives in the hi lane
	parameter int BURST_W         = 8;

	parameter logic [BURST_W-1:0] RA_BURST_LEN = 8'd1;   // region reader fetches single words

	// register map, byte addresses on the host bus
	parameter logic [REG_ADDR_W-1:0] ID_ADDR            = 16'h0000;   // ro device id
	parameter logic [REG_ADDR_W-1:0] REVISION_ADDR      = 16'h0004;   // ro revision
	parameter logic [REG_ADDR_W-1:0] SOFTRESET_ADDR     = 16'h0008;   // core and ta soft reset
	parameter logic [REG_ADDR_W-1:0] STARTRENDER_ADDR   = 16'h0014;   // drawing start
	parameter logic [REG_ADDR_W-1:0] FB_W_CTRL_ADDR     = 16'h0048;   // fb write control
	parameter logic [REG_ADDR_W-1:0] FB_X_CLIP_ADDR     = 16'h0068;   // pixel clip x
	parameter logic [REG_ADDR_W-1:0] FB_Y_CLIP_ADDR     = 16'h006C;   // pixel clip y
	parameter logic [REG_ADDR_W-1:0] ISP_BACKGND_D_ADDR = 16'h0088;   // background depth
	parameter logic [REG_ADDR_W-1:0] ISP_BACKGND_T_ADDR = 16'h008C;   // background tag
	parameter logic [REG_ADDR_W-1:0] TEXT_CONTROL_ADDR  = 16'h00E4;   // texturing control

	parameter logic [3:0] PAL_WINDOW_TAG = 4'h1;   // addr[15:12], covers 0x1000..0x1ffc

	parameter logic [REG_DATA_W-1:0] PVR_ID_VALUE       = 32'h17FD11DB;
	parameter logic [REG_DATA_W-1:0] PVR_REVISION_VALUE = 32'h00000011;

	// one 64-bit vram word, seen either as two parameter lanes or as one texel fetch
	typedef union packed {
		struct packed {
			logic [REG_DATA_W-1:0] hi;   // bits 63:32
			logic [REG_DATA_W-1:0] lo;   // bits 31:0
		} lanes;
		logic [2*REG_DATA_W-1:0] texel;
	} vram_word_u;

endpackage

`default_nettype wire

//--- rtl/pvr_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_reg_file (
	input  wire                            clock,
	input  wire                            reset_n,
	pvr_bus_if.sink                        bus,
	input  wire                            reg_we,      // write outside the palette window
	input  wire                            pal_sel,     // address falls in the palette window
	input  wire [pvr_pkg::REG_DATA_W-1:0]  pal_rdata,   // combinational palette word
	output logic [pvr_pkg::REG_DATA_W-1:0] pvr_dout
);

	logic [pvr_pkg::REG_DATA_W-1:0] softreset;       // core and ta soft reset
	logic [pvr_pkg::REG_DATA_W-1:0] startrender;     // drawing start
	logic [pvr_pkg::REG_DATA_W-1:0] fb_w_ctrl;       // fb write format
	logic [pvr_pkg::REG_DATA_W-1:0] fb_x_clip;
	logic [pvr_pkg::REG_DATA_W-1:0] fb_y_clip;
	logic [pvr_pkg::REG_DATA_W-1:0] isp_backgnd_d;   // background plane depth
	logic [pvr_pkg::REG_DATA_W-1:0] isp_backgnd_t;   // background plane tag
	logic [pvr_pkg::REG_DATA_W-1:0] text_control;    // texture stride and swap bits

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			softreset     <= '0;
			startrender   <= '0;
			fb_w_ctrl     <= '0;
			fb_x_clip     <= '0;
			fb_y_clip     <= '0;
			isp_backgnd_d <= '0;
			isp_backgnd_t <= '0;
			text_control  <= '0;
		end else if (reg_we) begin
			case (bus.addr)
				pvr_pkg::SOFTRESET_ADDR:     softreset     <= bus.wdata;
				pvr_pkg::STARTRENDER_ADDR:   startrender   <= bus.wdata;
				pvr_pkg::FB_W_CTRL_ADDR:     fb_w_ctrl     <= bus.wdata;
				pvr_pkg::FB_X_CLIP_ADDR:     fb_x_clip     <= bus.wdata;
				pvr_pkg::FB_Y_CLIP_ADDR:     fb_y_clip     <= bus.wdata;
				pvr_pkg::ISP_BACKGND_D_ADDR: isp_backgnd_d <= bus.wdata;
				pvr_pkg::ISP_BACKGND_T_ADDR: isp_backgnd_t <= bus.wdata;
				pvr_pkg::TEXT_CONTROL_ADDR:  text_control  <= bus.wdata;
				default: ;   // id, revision and holes drop the write
			endcase
		end
	end

	// read mux follows the address level, result lands one edge later
	always_ff @(posedge clock) begin
		if (pal_sel) begin
			pvr_dout <= pal_rdata;
		end else begin
			case (bus.addr)
				pvr_pkg::ID_ADDR:            pvr_dout <= pvr_pkg::PVR_ID_VALUE;
				pvr_pkg::REVISION_ADDR:      pvr_dout <= pvr_pkg::PVR_REVISION_VALUE;
				pvr_pkg::SOFTRESET_ADDR:     pvr_dout <= softreset;
				pvr_pkg::STARTRENDER_ADDR:   pvr_dout <= startrender;
				pvr_pkg::FB_W_CTRL_ADDR:     pvr_dout <= fb_w_ctrl;
				pvr_pkg::FB_X_CLIP_ADDR:     pvr_dout <= fb_x_clip;
				pvr_pkg::FB_Y_CLIP_ADDR:     pvr_dout <= fb_y_clip;
				pvr_pkg::ISP_BACKGND_D_ADDR: pvr_dout <= isp_backgnd_d;
				pvr_pkg::ISP_BACKGND_T_ADDR: pvr_dout <= isp_backgnd_t;
				pvr_pkg::TEXT_CONTROL_ADDR:  pvr_dout <= text_control;
				default: ;   // unmapped, keep the last word
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/pvr_top.sv
`timescale 1ns/1ps
`default_nettype none

module pvr_top #(
	parameter int VRAM_ADDR_W = 22   // 4MB of vram words by default
) (
	input  wire                                 clock,
	input  wire                                 reset_n,
	input  wire                                 pvr_reg_cs,          // host register bus
	input  wire [pvr_pkg::REG_ADDR_W-1:0]       pvr_addr,
	input  wire [pvr_pkg::REG_DATA_W-1:0]       pvr_din,
	input  wire                                 pvr_wr,
	output logic [pvr_pkg::REG_DATA_W-1:0]      pvr_dout,
	input  wire                                 param_word_swap,
	input  wire                                 tex_word_swap,
	input  wire                                 ra_vram_rd,          // region array reader
	input  wire                                 ra_vram_wr,
	input  wire [pvr_pkg::VRAM_REQ_ADDR_W-1:0]  ra_vram_addr,
	input  wire [pvr_pkg::REG_DATA_W-1:0]       ra_vram_wdata,
	output logic [pvr_pkg::REG_DATA_W-1:0]      ra_vram_rdata,
	input  wire                                 isp_vram_rd,         // isp parser
	input  wire                                 isp_vram_wr,
	input  wire [pvr_pkg::VRAM_REQ_ADDR_W-1:0]  isp_vram_addr,
	input  wire [pvr_pkg::REG_DATA_W-1:0]       isp_vram_wdata,
	input  wire [pvr_pkg::BURST_W-1:0]          isp_vram_burst_cnt,
	output logic [pvr_pkg::REG_DATA_W-1:0]      isp_vram_rdata,
	input  wire                                 render_poly,         // ownership strobes
	input  wire                                 render_to_tile,
	input  wire                                 poly_drawn,
	input  wire                                 tile_accum_done,
	output logic                                vram_rd,
	output logic                                vram_wr,
	output logic [VRAM_ADDR_W-1:0]              vram_addr,
	output logic [pvr_pkg::BURST_W-1:0]         vram_burst_cnt,
	output logic [pvr_pkg::REG_DATA_W-1:0]      vram_dout,
	input  wire [$bits(pvr_pkg::vram_word_u)-1:0] vram_din,
	output logic [$bits(pvr_pkg::vram_word_u)-1:0] tex_rdata
);

	pvr_bus_if     bus();
	vram_client_if ra_vif();
	vram_client_if isp_vif();

	logic                           reg_we;
	logic                           pal_we;
	logic                           pal_sel;
	logic                           isp_owns;
	logic [pvr_pkg::REG_DATA_W-1:0] pal_rdata;
	pvr_pkg::vram_word_u            vram_word;   // vram_din seen as lanes or texel
	pvr_pkg::vram_word_u            tex_word;

	assign bus.cs    = pvr_reg_cs;
	assign bus.addr  = pvr_addr;
	assign bus.wdata = pvr_din;
	assign bus.wr    = pvr_wr;

	assign ra_vif.rd     = ra_vram_rd;
	assign ra_vif.wr     = ra_vram_wr;
	assign ra_vif.addr   = ra_vram_addr;
	assign ra_vif.wdata  = ra_vram_wdata;
	assign ra_vram_rdata = ra_vif.rdata;

	assign isp_vif.rd     = isp_vram_rd;
	assign isp_vif.wr     = isp_vram_wr;
	assign isp_vif.addr   = isp_vram_addr;
	assign isp_vif.wdata  = isp_vram_wdata;
	assign isp_vram_rdata = isp_vif.rdata;

	assign vram_word = vram_din;
	assign tex_rdata = tex_word.texel;

	pvr_ctrl u_ctrl (
		.clock(clock), .reset_n(reset_n), .bus(bus),
		.render_poly(render_poly), .render_to_tile(render_to_tile),
		.poly_drawn(poly_drawn), .tile_accum_done(tile_accum_done),
		.reg_we(reg_we), .pal_we(pal_we), .pal_sel(pal_sel), .isp_owns(isp_owns)
	);

	pvr_reg_file u_reg_file (
		.clock(clock), .reset_n(reset_n), .bus(bus), .reg_we(reg_we),
		.pal_sel(pal_sel), .pal_rdata(pal_rdata), .pvr_dout(pvr_dout)
	);

	pvr_palette_ram u_palette_ram (
		.clock(clock), .bus(bus), .pal_we(pal_we), .pal_rdata(pal_rdata)
	);

	vram_port_mux #(.VRAM_ADDR_W(VRAM_ADDR_W)) u_vram_port_mux (
		.ra(ra_vif), .isp(isp_vif), .isp_burst_cnt(isp_vram_burst_cnt),
		.isp_owns(isp_owns), .param_word_swap(param_word_swap),
		.tex_word_swap(tex_word_swap), .vram_rd(vram_rd), .vram_wr(vram_wr),
		.vram_addr(vram_addr), .vram_burst_cnt(vram_burst_cnt),
		.vram_dout(vram_dout), .vram_din(vram_word), .tex_rdata(tex_word)
	);

endmodule

`default_nettype wire

//--- rtl/vram_client_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vram_client_if;

	logic                                rd;      // read strobe toward vram
	logic                                wr;      // write strobe toward vram
	logic [pvr_pkg::VRAM_REQ_ADDR_W-1:0] addr;    // full request address, bit 22 picks the lane
	logic [pvr_pkg::REG_DATA_W-1:0]      wdata;
	logic [pvr_pkg::REG_DATA_W-1:0]      rdata;   // 32-bit lane cut from the vram word

	// requester side
	modport client (
		output rd, wr, addr, wdata,
		input  rdata
	);

	// the shared vram port
	modport port (
		input  rd, wr, addr, wdata,
		output rdata
	);

endinterface

`default_nettype wire

//--- rtl/vram_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module vram_port_mux #(
	parameter int VRAM_ADDR_W = 22   // physical vram address width, 20..24
) (
	vram_client_if.port                    ra,
	vram_client_if.port                    isp,
	input  wire [pvr_pkg::BURST_W-1:0]     isp_burst_cnt,
	input  wire                            isp_owns,          // 0 = region reader has the port
	input  wire                            param_word_swap,   // flips the lane choice
	input  wire                            tex_word_swap,     // exchanges texel halves
	output logic                           vram_rd,
	output logic                           vram_wr,
	output logic [VRAM_ADDR_W-1:0]         vram_addr,
	output logic [pvr_pkg::BURST_W-1:0]    vram_burst_cnt,
	output logic [pvr_pkg::REG_DATA_W-1:0] vram_dout,
	input  wire pvr_pkg::vram_word_u       vram_din,
	output pvr_pkg::vram_word_u            tex_rdata
);

	// lane for one client, bit 22 selects the upper half unless swapped
	function automatic logic [pvr_pkg::REG_DATA_W-1:0] pick_lane(
		input logic [pvr_pkg::VRAM_REQ_ADDR_W-1:0] addr,
		input logic                                swap,
		input pvr_pkg::vram_word_u                 word
	);
		return (addr[pvr_pkg::LANE_SEL_BIT] ^ swap) ? word.lanes.hi : word.lanes.lo;
	endfunction

	// request side, owner goes straight through
	assign vram_rd        = isp_owns ? isp.rd : ra.rd;
	assign vram_wr        = isp_owns ? isp.wr : ra.wr;
	assign vram_addr      = isp_owns ? isp.addr[VRAM_ADDR_W-1:0] : ra.addr[VRAM_ADDR_W-1:0];
	assign vram_burst_cnt = isp_owns ? isp_burst_cnt : pvr_pkg::RA_BURST_LEN;
	assign vram_dout      = isp_owns ? isp.wdata : ra.wdata;

	// read side, both clients see the bus, each picks its own lane
	assign ra.rdata  = pick_lane(ra.addr, param_word_swap, vram_din);
	assign isp.rdata = pick_lane(isp.addr, param_word_swap, vram_din);

	assign tex_rdata = tex_word_swap ? {vram_din.lanes.lo, vram_din.lanes.hi} : vram_din.texel;

endmodule

`default_nettype wire
